//--- Makefile
# Verilator simulation of the PWM timer block
LOG := sim.log

sim:
	verilator --binary --timing -f sim.f --top-module pwm_tb -Mdir obj_dir
	./obj_dir/Vpwm_tb | tee $(LOG)
	grep -q "All checks passed" $(LOG)

clean:
	rm -rf obj_dir $(LOG)

.PHONY: sim clean

//--- sim.f
src/pwm_pkg.sv
src/pwm_regs.sv
src/pwm_prescaler.sv
src/pwm_timer.sv
src/pwm_top.sv
tests/pwm_tb.sv

//--- src/pwm_pkg.sv
// Shared types and constants for the two-timer PWM block.
// Holds the register map, mode encodings and the structs that
// carry config, counter loads, prescaler ticks and interrupt pulses.

package pwm_pkg;

    // ==============================
    // Widths and limits
    // ==============================
    localparam int CNT_W   = 8;    // Counter and bus data word
    localparam int ADDR_W  = 8;    // Bus address
    localparam int PRESC_W = 10;   // Shared prescaler, covers /1024
    localparam logic [CNT_W-1:0] CNT_MAX = 8'hFF;

    // Register map, AVR I/O addresses
    typedef enum logic [ADDR_W-1:0] {
        TCCR0A = 8'h44,
        TCCR0B = 8'h45,
        TCNT0  = 8'h46,
        OCR0A  = 8'h47,
        OCR0B  = 8'h48,
        TCCR2A = 8'hB0,
        TCCR2B = 8'hB1,
        TCNT2  = 8'hB2,
        OCR2A  = 8'hB3,
        OCR2B  = 8'hB4
    } reg_addr_e;

    // Waveform mode, WGM == 3 is fast PWM
    typedef enum logic {
        NORMAL   = 1'b0,
        FAST_PWM = 1'b1
    } wave_mode_e;

    // Compare output mode, first two leave the pin alone
    typedef enum logic [1:0] {
        COM_OFF         = 2'b00,
        COM_TOGGLE_RSVD = 2'b01,
        COM_NONINV      = 2'b10,
        COM_INV         = 2'b11
    } com_mode_e;

    // Clock select; raw codes 6 and 7 fold into CS_STOP
    typedef enum logic [2:0] {
        CS_STOP    = 3'd0,
        CS_DIV1    = 3'd1,
        CS_DIV8    = 3'd2,
        CS_DIV64   = 3'd3,
        CS_DIV256  = 3'd4,
        CS_DIV1024 = 3'd5
    } clk_sel_e;

    // ==============================
    // Structs between blocks
    // ==============================
    typedef struct packed {
        wave_mode_e       mode;
        com_mode_e        com_a;
        com_mode_e        com_b;
        clk_sel_e         clk_sel;
        logic [CNT_W-1:0] ocr_a;
        logic [CNT_W-1:0] ocr_b;
    } timer_cfg_t;

    typedef struct packed {
        logic             load;    // One clock, same cycle as the write
        logic [CNT_W-1:0] value;
    } cnt_load_t;

    typedef struct packed {
        logic ovf;
        logic comp_a;
        logic comp_b;
    } timer_irq_t;

    typedef struct packed {
        logic div8;
        logic div64;
        logic div256;
        logic div1024;
    } presc_tick_t;

endpackage

//--- src/pwm_prescaler.sv
// Shared prescaler for both timers.
// A free-running counter gives one-clock ticks every 8, 64, 256 and 1024
// cycles; each timer picks its own tick from the set.

`timescale 1ns/1ps

module pwm_prescaler (
    input  logic                 clk,
    input  logic                 rst_n,
    output pwm_pkg::presc_tick_t tick
);
    import pwm_pkg::*;

    logic [PRESC_W-1:0] presc_cnt;

    // Free-running, wraps every 1024 clocks
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            presc_cnt <= '0;
        end else begin
            presc_cnt <= presc_cnt + 1'b1;
        end
    end

    // Tick when low bits are all ones, single cycle wide
    assign tick.div8    = &presc_cnt[2:0];
    assign tick.div64   = &presc_cnt[5:0];
    assign tick.div256  = &presc_cnt[7:0];
    assign tick.div1024 = &presc_cnt[9:0];   // Full counter

endmodule

//--- src/pwm_regs.sv
// Register file for timer 0 and timer 2.
// Bus writes land on the rising edge with cs and we high; reads are
// combinational while cs and re are high. TCNT writes become load strobes.

`timescale 1ns/1ps

module pwm_regs (
    input  logic                       clk,
    input  logic                       rst_n,
    input  logic                       cs,
    input  logic                       we,
    input  logic                       re,
    input  logic [pwm_pkg::ADDR_W-1:0] addr,
    input  logic [pwm_pkg::CNT_W-1:0]  wdata,
    output logic [pwm_pkg::CNT_W-1:0]  rdata,
    input  logic [pwm_pkg::CNT_W-1:0]  cnt0,
    input  logic [pwm_pkg::CNT_W-1:0]  cnt2,
    output pwm_pkg::timer_cfg_t        cfg0,
    output pwm_pkg::timer_cfg_t        cfg2,
    output pwm_pkg::cnt_load_t         load0,
    output pwm_pkg::cnt_load_t         load2
);
    import pwm_pkg::*;

    logic [CNT_W-1:0] tccr0a, tccr0b, ocr0a, ocr0b;
    logic [CNT_W-1:0] tccr2a, tccr2b, ocr2a, ocr2b;
    logic             wr_en;   // Bus write this cycle

    // Control bytes to decoded timer settings
    function automatic timer_cfg_t decode_cfg(
        input logic [CNT_W-1:0] tccr_a,
        input logic [CNT_W-1:0] tccr_b,
        input logic [CNT_W-1:0] ocr_a,
        input logic [CNT_W-1:0] ocr_b
    );
        timer_cfg_t c;
        logic [2:0] wgm;
        wgm       = {tccr_b[3], tccr_a[1:0]};
        c.mode    = (wgm == 3'd3) ? FAST_PWM : NORMAL;   // Only mode 3 is PWM here
        c.com_a   = com_mode_e'(tccr_a[7:6]);
        c.com_b   = com_mode_e'(tccr_a[5:4]);
        c.clk_sel = (tccr_b[2:0] > 3'd5) ? CS_STOP : clk_sel_e'(tccr_b[2:0]);  // Ext clk n/a
        c.ocr_a   = ocr_a;
        c.ocr_b   = ocr_b;
        return c;
    endfunction

    assign wr_en = cs && we;

    // ==============================
    // Write side
    // ==============================
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            tccr0a <= '0;
            tccr0b <= '0;
            ocr0a  <= '0;
            ocr0b  <= '0;
            tccr2a <= '0;
            tccr2b <= '0;
            ocr2a  <= '0;
            ocr2b  <= '0;
        end else if (wr_en) begin
            case (addr)
                TCCR0A: tccr0a <= wdata;
                TCCR0B: tccr0b <= wdata;
                OCR0A:  ocr0a  <= wdata;
                OCR0B:  ocr0b  <= wdata;
                TCCR2A: tccr2a <= wdata;
                TCCR2B: tccr2b <= wdata;
                OCR2A:  ocr2a  <= wdata;
                OCR2B:  ocr2b  <= wdata;
                default: ;     // TCNT goes out as a load, rest unmapped
            endcase
        end
    end

    // Counter loads, timer owns the count itself
    assign load0.load  = wr_en && (addr == TCNT0);
    assign load0.value = wdata;
    assign load2.load  = wr_en && (addr == TCNT2);
    assign load2.value = wdata;

    assign cfg0 = decode_cfg(tccr0a, tccr0b, ocr0a, ocr0b);
    assign cfg2 = decode_cfg(tccr2a, tccr2b, ocr2a, ocr2b);

    // ==============================
    // Read side
    // ==============================
    always_comb begin
        rdata = '0;
        if (cs && re) begin
            case (addr)
                TCCR0A:  rdata = tccr0a;
                TCCR0B:  rdata = tccr0b;
                TCNT0:   rdata = cnt0;     // Live count
                OCR0A:   rdata = ocr0a;
                OCR0B:   rdata = ocr0b;
                TCCR2A:  rdata = tccr2a;
                TCCR2B:  rdata = tccr2b;
                TCNT2:   rdata = cnt2;
                OCR2A:   rdata = ocr2a;
                OCR2B:   rdata = ocr2b;
                default: rdata = '0;
            endcase
        end
    end

endmodule

//--- src/pwm_timer.sv
// One 8-bit timer: counter with bus load, overflow and compare pulses,
// and two fast PWM output generators. Instantiated once per timer.

`timescale 1ns/1ps

module pwm_timer (
    input  logic                      clk,
    input  logic                      rst_n,
    input  pwm_pkg::timer_cfg_t       cfg,
    input  pwm_pkg::cnt_load_t        load,
    input  pwm_pkg::presc_tick_t      tick,
    output logic [pwm_pkg::CNT_W-1:0] cnt,
    output pwm_pkg::timer_irq_t       irq,
    output logic                      pwm_a,
    output logic                      pwm_b
);
    import pwm_pkg::*;

    logic step;       // Counting step this clock
    logic count_en;   // Step not overridden by a load

    // Next output level for one channel in fast PWM
    function automatic logic pwm_next(
        input logic             cur,
        input com_mode_e        com,
        input logic [CNT_W-1:0] count,
        input logic [CNT_W-1:0] ocr
    );
        logic nxt;
        nxt = cur;
        case (com)
            COM_NONINV: begin
                if (count == '0)  nxt = 1'b1;   // Set at bottom
                if (count == ocr) nxt = 1'b0;   // Clear on match, wins
            end
            COM_INV: begin
                if (count == '0)  nxt = 1'b0;
                if (count == ocr) nxt = 1'b1;
            end
            default: nxt = cur;                 // Pin left alone
        endcase
        return nxt;
    endfunction

    // ==============================
    // Clock select
    // ==============================
    always_comb begin
        case (cfg.clk_sel)
            CS_DIV1:    step = 1'b1;
            CS_DIV8:    step = tick.div8;
            CS_DIV64:   step = tick.div64;
            CS_DIV256:  step = tick.div256;
            CS_DIV1024: step = tick.div1024;
            default:    step = 1'b0;            // Stopped
        endcase
    end

    assign count_en = step && !load.load;

    // ==============================
    // Counter and interrupt pulses
    // ==============================
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            cnt <= '0;
        end else if (load.load) begin
            cnt <= load.value;                  // Bus write has priority
        end else if (step) begin
            cnt <= cnt + 1'b1;                  // Wraps 0xFF -> 0
        end
    end

    // One-clock pulses, same rules in both modes
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            irq <= '0;
        end else begin
            irq.ovf    <= count_en && (cnt == CNT_MAX);
            irq.comp_a <= count_en && (cnt == cfg.ocr_a);
            irq.comp_b <= count_en && (cnt == cfg.ocr_b);
        end
    end

    // ==============================
    // Waveform outputs
    // ==============================
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            pwm_a <= 1'b0;
            pwm_b <= 1'b0;
        end else if (cfg.mode == FAST_PWM) begin
            pwm_a <= pwm_next(pwm_a, cfg.com_a, cnt, cfg.ocr_a);
            pwm_b <= pwm_next(pwm_b, cfg.com_b, cnt, cfg.ocr_b);
        end
        // Normal mode holds the pins
    end

endmodule

//--- src/pwm_top.sv
// Top of the PWM timer block: register file, shared prescaler and the
// two 8-bit timers (0 and 2) on one cs/we/re register bus.

`timescale 1ns/1ps

module pwm_top (
    input  logic                       clk,
    input  logic                       rst_n,
    input  logic                       cs,
    input  logic                       we,
    input  logic                       re,
    input  logic [pwm_pkg::ADDR_W-1:0] addr,
    input  logic [pwm_pkg::CNT_W-1:0]  wdata,
    output logic [pwm_pkg::CNT_W-1:0]  rdata,
    output logic                       pwm0_a,
    output logic                       pwm0_b,
    output logic                       pwm2_a,
    output logic                       pwm2_b,
    output pwm_pkg::timer_irq_t        irq0,
    output pwm_pkg::timer_irq_t        irq2
);
    import pwm_pkg::*;

    timer_cfg_t       cfg0, cfg2;
    cnt_load_t        load0, load2;
    presc_tick_t      tick;
    logic [CNT_W-1:0] cnt0, cnt2;   // Live counts for readback

    // ==============================
    // Bus side
    // ==============================
    pwm_regs u_regs (
        .clk   (clk),
        .rst_n (rst_n),
        .cs    (cs),
        .we    (we),
        .re    (re),
        .addr  (addr),
        .wdata (wdata),
        .rdata (rdata),
        .cnt0  (cnt0),
        .cnt2  (cnt2),
        .cfg0  (cfg0),
        .cfg2  (cfg2),
        .load0 (load0),
        .load2 (load2)
    );

    pwm_prescaler u_prescaler (
        .clk   (clk),
        .rst_n (rst_n),
        .tick  (tick)
    );

    // ==============================
    // Timers
    // ==============================
    pwm_timer u_timer0 (
        .clk   (clk),
        .rst_n (rst_n),
        .cfg   (cfg0),
        .load  (load0),
        .tick  (tick),
        .cnt   (cnt0),
        .irq   (irq0),
        .pwm_a (pwm0_a),
        .pwm_b (pwm0_b)
    );

    pwm_timer u_timer2 (
        .clk   (clk),
        .rst_n (rst_n),
        .cfg   (cfg2),
        .load  (load2),
        .tick  (tick),
        .cnt   (cnt2),
        .irq   (irq2),
        .pwm_a (pwm2_a),
        .pwm_b (pwm2_b)
    );

endmodule

//--- tests/pwm_patterns.txt
# Fields hex. W addr data, R addr expected, D timer chan(0=a 1=b) divider ocr inverted
# P timer divider (normal mode period and compare pulses), H timer (count holds when stopped)
R 44 00
R 45 00
R 46 00
R 47 00
R 48 00
R B0 00
R B1 00
R B2 00
R B3 00
R B4 00
R 00 00
W 44 A3
W 47 40
W 48 C0
W 46 5A
R 44 A3
R 47 40
R 48 C0
R 46 5A
W B0 A3
W B3 C0
W B4 40
W B2 33
R B0 A3
R B3 C0
R B4 40
R B2 33
# Fast PWM non-inverting at /1
W 45 01
W B1 01
R 45 01
R B1 01
D 0 0 1 40 0
D 0 1 1 C0 0
D 2 0 1 C0 0
D 2 1 1 40 0
W 47 00
D 0 0 1 00 0
# Fast PWM inverting at /8
W 44 F3
W 45 02
W 47 40
D 0 0 8 40 1
D 0 1 8 C0 1
# Normal mode overflow period
W 44 00
W 45 01
P 0 1
W 45 03
P 0 40
W B0 00
P 2 1
# Stop halts the count
W 45 00
H 0
W B1 00
H 2

//--- tests/pwm_tb.sv
// Testbench for the two-timer PWM block.
// Runs the operations in tests/pwm_patterns.txt against pwm_top: bus writes and
// reads, duty measurement in fast PWM and overflow period measurement.

`timescale 1ns/1ps

module pwm_tb;
    import pwm_pkg::*;

    localparam int OVF_TIMEOUT = 256 * 1024 * 3;   // Cycles allowed per ovf wait

    logic                clk;
    logic                rst_n;
    logic                cs, we, re;
    logic [ADDR_W-1:0]   addr;
    logic [CNT_W-1:0]    wdata;
    logic [CNT_W-1:0]    rdata;
    logic                pwm0_a, pwm0_b, pwm2_a, pwm2_b;
    timer_irq_t          irq0, irq2;

    pwm_top dut (
        .clk    (clk),
        .rst_n  (rst_n),
        .cs     (cs),
        .we     (we),
        .re     (re),
        .addr   (addr),
        .wdata  (wdata),
        .rdata  (rdata),
        .pwm0_a (pwm0_a),
        .pwm0_b (pwm0_b),
        .pwm2_a (pwm2_a),
        .pwm2_b (pwm2_b),
        .irq0   (irq0),
        .irq2   (irq2)
    );

    always #5 clk = ~clk;   // 10 ns period

    // ==============================
    // Signal pickers and helpers
    // ==============================
    function automatic logic pwm_level(input int t, input int ch);
        if (t == 2) return (ch == 1) ? pwm2_b : pwm2_a;
        return (ch == 1) ? pwm0_b : pwm0_a;
    endfunction

    function automatic logic ovf_of(input int t);
        return (t == 2) ? irq2.ovf : irq0.ovf;
    endfunction

    function automatic logic comp_of(input int t, input int ch);
        if (t == 2) return (ch == 1) ? irq2.comp_b : irq2.comp_a;
        return (ch == 1) ? irq0.comp_b : irq0.comp_a;
    endfunction

    task automatic fail_stop(input string msg);
        $display("%s", msg);
        $display("Checks failed");
        $fatal(1, "Simulation stopped");
    endtask

    task automatic check_value(input string name, input int got, input int exp);
        if (got != exp)
            fail_stop($sformatf("Fail at %0t: %s got 0x%0h expected 0x%0h",
                                $time, name, got, exp));
    endtask

    task automatic bus_write(input int a, input int d);
        @(negedge clk);
        addr  = a[ADDR_W-1:0];
        wdata = d[CNT_W-1:0];
        cs    = 1'b1;
        we    = 1'b1;
        @(negedge clk);            // Write lands on the rising edge between
        cs    = 1'b0;
        we    = 1'b0;
    endtask

    task automatic bus_read(input int a, output int d);
        @(negedge clk);
        addr = a[ADDR_W-1:0];
        cs   = 1'b1;
        re   = 1'b1;
        #2 d = int'(rdata);        // Mid low phase, well clear of the edge
        @(negedge clk);
        cs   = 1'b0;
        re   = 1'b0;
    endtask

    // Next ovf pulse, seen at a falling edge
    task automatic wait_ovf(input int t);
        int n;
        n = 0;
        @(negedge clk);
        while (!ovf_of(t)) begin
            if (n >= OVF_TIMEOUT)
                fail_stop($sformatf("Timed out waiting for overflow of timer %0d", t));
            n++;
            @(negedge clk);
        end
    endtask

    // ==============================
    // Measurements
    // ==============================
    task automatic measure_duty(input int t, input int ch, input int div, input int ocr,
                                input int inv);
        int got;
        int n;
        logic active;
        active = (inv == 0);               // Non-inverting counts high cycles
        wait_ovf(t);
        wait_ovf(t);                       // Second ovf, waveform settled
        got = 0;
        for (n = 0; n < 256 * div; n++) begin
            if (pwm_level(t, ch) == active) got++;
            @(negedge clk);
        end
        check_value($sformatf("pwm%0d_%s active cycles", t, (ch == 1) ? "b" : "a"),
                    got, ocr * div);
    endtask

    task automatic measure_period(input int t, input int div);
        int cycles, n_a, n_b;
        int tccra;
        logic lvl_a, lvl_b;
        bus_read((t == 2) ? TCCR2A : TCCR0A, tccra);
        bus_write((t == 2) ? TCCR2A : TCCR0A, tccra | 32'hA0);   // COM bits on, WGM kept
        wait_ovf(t);
        wait_ovf(t);                       // First full period after the config write
        lvl_a  = pwm_level(t, 0);
        lvl_b  = pwm_level(t, 1);
        cycles = 0;
        n_a    = 0;
        n_b    = 0;
        do begin
            @(negedge clk);
            cycles++;
            if (comp_of(t, 0)) n_a++;
            if (comp_of(t, 1)) n_b++;
            check_value($sformatf("pwm%0d_a in normal mode", t), pwm_level(t, 0), lvl_a);
            check_value($sformatf("pwm%0d_b in normal mode", t), pwm_level(t, 1), lvl_b);
            if (cycles > OVF_TIMEOUT)
                fail_stop($sformatf("Timed out waiting for overflow of timer %0d", t));
        end while (!ovf_of(t));
        check_value($sformatf("irq%0d ovf period", t), cycles, 256 * div);
        check_value($sformatf("irq%0d comp_a pulses", t), n_a, 1);
        check_value($sformatf("irq%0d comp_b pulses", t), n_b, 1);
        bus_write((t == 2) ? TCCR2A : TCCR0A, tccra);   // Back to the pattern's setting
    endtask

    // Stopped timer keeps its count
    task automatic check_hold(input int t);
        int first, second;
        bus_read((t == 2) ? 32'hB2 : 32'h46, first);
        repeat (100) @(negedge clk);
        bus_read((t == 2) ? 32'hB2 : 32'h46, second);
        check_value($sformatf("tcnt%0d while stopped", t), second, first);
    endtask

    // ==============================
    // Main sequence
    // ==============================
    initial begin : run
        int fd, op, c, n, got;
        int f1, f2, f3, f4, f5;
        clk   = 1'b0;
        rst_n = 1'b0;
        cs    = 1'b0;
        we    = 1'b0;
        re    = 1'b0;
        addr  = '0;
        wdata = '0;
        repeat (10) @(negedge clk);
        rst_n = 1'b1;

        for (n = 0; n < 50; n++) begin     // Quiet after reset
            @(negedge clk);
            check_value("outputs after reset",
                        int'({pwm0_a, pwm0_b, pwm2_a, pwm2_b, irq0, irq2}), 0);
        end

        fd = $fopen("tests/pwm_patterns.txt", "r");
        if (fd == 0) fail_stop("Could not open tests/pwm_patterns.txt");
        while ($fscanf(fd, " %c", op) == 1) begin
            case (op)
                "#": begin                 // Comment, skip rest of line
                    c = $fgetc(fd);
                    while (c != 10 && c != -1) c = $fgetc(fd);
                end
                "W": begin
                    if ($fscanf(fd, "%h %h", f1, f2) != 2) fail_stop("Bad W line in patterns");
                    bus_write(f1, f2);
                end
                "R": begin
                    if ($fscanf(fd, "%h %h", f1, f2) != 2) fail_stop("Bad R line in patterns");
                    bus_read(f1, got);
                    check_value($sformatf("rdata at 0x%0h", f1), got, f2);
                end
                "D": begin
                    if ($fscanf(fd, "%h %h %h %h %h", f1, f2, f3, f4, f5) != 5)
                        fail_stop("Bad D line in patterns");
                    measure_duty(f1, f2, f3, f4, f5);
                end
                "P": begin
                    if ($fscanf(fd, "%h %h", f1, f2) != 2) fail_stop("Bad P line in patterns");
                    measure_period(f1, f2);
                end
                "H": begin
                    if ($fscanf(fd, "%h", f1) != 1) fail_stop("Bad H line in patterns");
                    check_hold(f1);
                end
                default: fail_stop("Unknown operation in pattern file");
            endcase
        end
        $fclose(fd);

        $display("All checks passed");
        $finish;
    end

endmodule
